/* lbm_solver.f */
+incdir+tb
design/lbm_pkg.sv
design/lattice_mem.sv
design/sweep_ctrl.sv
design/stream_unit.sv
design/wb_host_port.sv
design/lbm_solver.sv
tb/tb_lbm_solver.sv

/* tb/lbm_model.svh */
`ifndef LBM_MODEL_SVH
`define LBM_MODEL_SVH

// Reference copy of both pages, indexed [page][direction][cell]
dist_t ref_lat [2][num_dir][lat_depth];
int    ref_page  = 0;
int    ref_steps = 0;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// North is the row above, so one row is lat_width cells
function automatic int neighbour_offset(input int d);
    case (dir_t'(d))
        d_n:     return -lat_width;
        d_ne:    return -lat_width + 1;
        d_e:     return 1;
        d_se:    return lat_width + 1;
        d_s:     return lat_width;
        d_sw:    return lat_width - 1;
        d_w:     return -1;
        d_nw:    return -lat_width - 1;
        default: return 0;
    endcase
endfunction

function automatic void init_pages(input logic [lat_depth-1:0] bar, input dist_vec_t init);
    for (int p = 0; p < 2; p++)
        for (int d = 0; d < num_dir; d++)
            for (int c = 0; c < lat_depth; c++)
                ref_lat[p][d][c] = bar[c] ? dist_t'(0) : init[d];
    ref_page  = 0;
    ref_steps = 0;
endfunction

// Stream, zero barriers, swap. Untouched entries of the next page keep old values
function automatic void step_pages(input logic [lat_depth-1:0] bar);
    int nxt;
    int c;
    nxt = 1 - ref_page;
    for (int row = 1; row < lat_height - 1; row++)
    begin
        for (int col = 1; col < lat_width - 1; col++)
        begin
            c = row * lat_width + col;
            if (!bar[c])
                for (int d = 0; d < num_dir; d++)
                    ref_lat[nxt][d][c + neighbour_offset(d)] = ref_lat[ref_page][d][c];
        end
    end
    for (int k = 0; k < lat_depth; k++)
        if (bar[k])
            for (int d = 0; d < num_dir; d++)
                ref_lat[nxt][d][k] = dist_t'(0);
    ref_page  = nxt;
    ref_steps = ref_steps + 1;
endfunction

`endif

/* tb/tb_lbm_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lbm_solver;
    import lbm_pkg::*;

    `include "lbm_model.svh"

    localparam int          seed        = 19101;
    localparam int          drive_delay = 1;
    // Corners 0 and 63, edges 3 and 24, interior 18, 27, 45
    localparam logic [63:0] barrier_map = (64'd1 << 0) | (64'd1 << 63) | (64'd1 << 3) |
                                          (64'd1 << 24) | (64'd1 << 18) | (64'd1 << 27) |
                                          (64'd1 << 45);

    typedef enum {op_wr_reg, op_rd_reg, op_rd_lat, op_rd_lat_held, op_wait_idle,
                  op_check_lattice} op_t;

    logic                     clk;
    logic                     rst;
    logic [lat_depth-1:0]     barriers;
    dist_vec_t                init_dist;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [data_width-1:0]    wb_dat_w;
    wire  [data_width-1:0]    wb_dat_r;
    wire                      wb_ack;

    // Stimulus table
    op_t                      row_op [$];
    logic [wb_addr_width-1:0] row_adr [$];
    logic [15:0]              row_dat [$];
    logic [15:0]              row_exp [$];
    string                    row_name [$];
    logic                     table_ready = 1'b0;

    int checks       = 0;
    int value_errors = 0;
    int other_errors = 0;

    lbm_solver UUT (
        .clk       (clk),
        .rst       (rst),
        .barriers  (barriers),
        .init_dist (init_dist),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_dist(input string name, input dist_t exp, input dist_t act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("[ERROR] %s: expected busy %b, actual busy %b", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////////////////////////

    function automatic logic [wb_addr_width-1:0] register_addr(input int r);
        return wb_addr_width'(r);    // Bit 10 low
    endfunction

    function automatic logic [wb_addr_width-1:0] lattice_addr(input int d, input int c);
        return {1'b1, 4'(d), 6'(c)};
    endfunction

    task automatic bus_access(input logic we, input logic [wb_addr_width-1:0] adr,
                              input logic [15:0] dat, output logic [15:0] rdata,
                              output int waited);
        @(posedge clk);
        #drive_delay;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        waited   = 0;
        @(posedge clk);
        #drive_delay;
        waited = 1;
        while (!wb_ack)
        begin
            @(posedge clk);
            #drive_delay;
            waited++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;    // Drop in the cycle after ack
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic poll_until_idle();
        logic [15:0] rdata;
        int          waited;
        rdata = 16'd1;
        while (rdata[0])
            bus_access(1'b0, register_addr(reg_status), 16'd0, rdata, waited);
    endtask

    task automatic verify_lattice(input string name);
        logic [15:0] rdata;
        int          waited;
        for (int d = 0; d < num_dir; d++)
        begin
            for (int c = 0; c < lat_depth; c++)
            begin
                bus_access(1'b0, lattice_addr(d, c), 16'd0, rdata, waited);
                check_dist($sformatf("%s dir %0d cell %0d", name, d, c),
                           ref_lat[ref_page][d][c], dist_t'(rdata));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input op_t op, input logic [wb_addr_width-1:0] adr,
                           input logic [15:0] dat, input logic [15:0] exp, input string name);
        row_op.push_back(op);
        row_adr.push_back(adr);
        row_dat.push_back(dat);
        row_exp.push_back(exp);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        add_row(op_check_lattice, '0, 16'd0, 16'd0, "init_lattice");
        add_row(op_rd_reg, register_addr(reg_step_count), 16'd0, 16'd0, "count_after_reset");
        add_row(op_wr_reg, register_addr(reg_step_target), 16'd1, 16'd0, "target_1");
        add_row(op_rd_reg, register_addr(reg_status), 16'd0, 16'd1, "status_busy");
        add_row(op_rd_reg, register_addr(reg_step_target), 16'd0, 16'd1, "target_readback");
        add_row(op_wait_idle, '0, 16'd0, 16'd0, "step_1_idle");
        add_row(op_rd_reg, register_addr(reg_step_count), 16'd0, 16'd1, "count_after_1");
        add_row(op_check_lattice, '0, 16'd0, 16'd0, "lattice_step_1");
        add_row(op_rd_lat, lattice_addr(d_e, 27), 16'd0, 16'd0, "barrier_cell_read");
        add_row(op_wr_reg, register_addr(reg_step_target), 16'd3, 16'd0, "target_3");
        add_row(op_wait_idle, '0, 16'd0, 16'd0, "step_3_idle");
        add_row(op_rd_reg, register_addr(reg_step_count), 16'd0, 16'd3, "count_after_3");
        add_row(op_check_lattice, '0, 16'd0, 16'd0, "lattice_step_3");
        add_row(op_wr_reg, register_addr(reg_step_target), 16'd4, 16'd0, "target_4");
        add_row(op_rd_lat_held, lattice_addr(d_ne, 20), 16'd0, 16'd0, "held_read");
        add_row(op_rd_reg, register_addr(reg_step_count), 16'd0, 16'd4, "count_after_4");
        add_row(op_check_lattice, '0, 16'd0, 16'd0, "lattice_step_4");
        add_row(op_wr_reg, register_addr(reg_step_target), 16'd4, 16'd0, "target_same");
        add_row(op_rd_reg, register_addr(reg_status), 16'd0, 16'd0, "status_no_step");
        add_row(op_rd_reg, register_addr(reg_step_count), 16'd0, 16'd4, "count_unchanged");
        add_row(op_check_lattice, '0, 16'd0, 16'd0, "lattice_unchanged");
    endtask

    task automatic apply_row(input int i);
        logic [15:0] rdata;
        int          waited;
        case (row_op[i])
            op_wr_reg:
            begin
                bus_access(1'b1, row_adr[i], row_dat[i], rdata, waited);
                if (waited != 1)
                begin
                    other_errors++;
                    $display("%s: register write was acknowledged after %0d cycles, not 1",
                             row_name[i], waited);
                end
                if (row_adr[i] == register_addr(reg_step_target))
                    while (ref_steps < int'(row_dat[i]))
                        step_pages(barrier_map);
            end

            op_rd_reg:
            begin
                bus_access(1'b0, row_adr[i], 16'd0, rdata, waited);
                if (waited != 1)
                begin
                    other_errors++;
                    $display("%s: register read was acknowledged after %0d cycles, not 1",
                             row_name[i], waited);
                end
                if (row_adr[i] == register_addr(reg_status))
                    check_status(row_name[i], row_exp[i][0], rdata[0]);
                else
                    check_count(row_name[i], row_exp[i], rdata);
            end

            op_rd_lat, op_rd_lat_held:
            begin
                bus_access(1'b0, row_adr[i], 16'd0, rdata, waited);
                check_dist(row_name[i], ref_lat[ref_page][row_adr[i][9:6]][row_adr[i][5:0]],
                           dist_t'(rdata));
                // A step takes at least one full zeroing sweep
                if (row_op[i] == op_rd_lat_held && waited <= lat_depth)
                begin
                    other_errors++;
                    $display("%s: lattice read was acknowledged after only %0d cycles, %s",
                             row_name[i], waited, "before the running step could finish");
                end
            end

            op_wait_idle:     poll_until_idle();
            op_check_lattice: verify_lattice(row_name[i]);
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] rng;
        rst      = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        barriers = barrier_map;
        rng      = 32'(seed);
        for (int d = 0; d < num_dir; d++)
        begin
            rng          = xorshift(rng);
            init_dist[d] = dist_t'(rng[15:0]);
        end
        init_pages(barrier_map, init_dist);
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #drive_delay;
        rst = 1'b1;

        for (int i = 0; i < row_op.size(); i++)
            apply_row(i);

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        int limit;
        int max_target;
        wait (table_ready);
        max_target = 0;
        limit      = lat_depth + 200;    // Init sweep and slack
        foreach (row_op[i])
        begin
            if (row_op[i] == op_wr_reg && row_adr[i] == register_addr(reg_step_target) &&
                int'(row_dat[i]) > max_target)
                max_target = int'(row_dat[i]);
            limit += (row_op[i] == op_check_lattice) ? num_dir * lat_depth * 4 : 16;
        end
        limit += max_target * (3 * lat_depth + lat_depth);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/lbm_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module lbm_solver (
    input  wire                                clk,
    input  wire                                rst,
    input  wire [lbm_pkg::lat_depth-1:0]       barriers,
    input  wire lbm_pkg::dist_vec_t            init_dist,
    input  wire                                wb_cyc,
    input  wire                                wb_stb,
    input  wire                                wb_we,
    input  wire [lbm_pkg::wb_addr_width-1:0]   wb_adr,
    input  wire [lbm_pkg::data_width-1:0]      wb_dat_w,
    output wire [lbm_pkg::data_width-1:0]      wb_dat_r,
    output wire                                wb_ack
);
    import lbm_pkg::*;

    // Sweep control
    sweep_phase_t phase;
    cell_addr_t   index;
    cell_addr_t   col;
    logic         page;
    logic         wait_done;
    logic         busy;
    logic [15:0]  step_count;
    logic         host_grant;

    // Host side
    logic [15:0]  step_target;
    cell_addr_t   host_cell;

    // Memory ports
    cell_addr_t [num_dir-1:0] mem_addr;
    logic [num_dir-1:0]       mem_page;
    logic [num_dir-1:0]       mem_we;
    dist_vec_t                mem_wdata;
    logic                     init_both;
    dist_vec_t                rd_data;

    sweep_ctrl u_sweep_ctrl (
        .clk         (clk),
        .rst         (rst),
        .barriers    (barriers),
        .step_target (step_target),
        .phase       (phase),
        .index       (index),
        .col         (col),
        .page        (page),
        .wait_done   (wait_done),
        .busy        (busy),
        .step_count  (step_count),
        .host_grant  (host_grant)
    );

    stream_unit u_stream_unit (
        .clk        (clk),
        .phase      (phase),
        .index      (index),
        .col        (col),
        .page       (page),
        .wait_done  (wait_done),
        .barriers   (barriers),
        .init_dist  (init_dist),
        .rd_data    (rd_data),
        .host_grant (host_grant),
        .host_cell  (host_cell),
        .mem_addr   (mem_addr),
        .mem_page   (mem_page),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .init_both  (init_both)
    );

    lattice_mem u_lattice_mem (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_page  (mem_page),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .init_both (init_both),
        .rd_data   (rd_data)
    );

    wb_host_port u_wb_host_port (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .busy        (busy),
        .step_count  (step_count),
        .host_grant  (host_grant),
        .rd_data     (rd_data),
        .step_target (step_target),
        .host_cell   (host_cell)
    );

endmodule

`default_nettype wire

/* design/wb_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_host_port (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                wb_cyc,
    input  wire                                wb_stb,
    input  wire                                wb_we,
    input  wire [lbm_pkg::wb_addr_width-1:0]   wb_adr,
    input  wire [lbm_pkg::data_width-1:0]      wb_dat_w,
    output logic [lbm_pkg::data_width-1:0]     wb_dat_r,
    output logic                               wb_ack,
    input  wire                                busy,
    input  wire [15:0]                         step_count,
    input  wire                                host_grant,
    input  wire lbm_pkg::dist_vec_t            rd_data,
    output logic [15:0]                        step_target,
    output lbm_pkg::cell_addr_t                host_cell
);
    import lbm_pkg::*;

    logic                  req;
    logic                  lat_sel;
    logic                  rd_pend;    // Lattice data on its way out of memory
    dir_t                  lane;
    int                    reg_off;
    logic [data_width-1:0] reg_rdata;

    assign req       = wb_cyc && wb_stb && !wb_ack;
    assign lat_sel   = wb_adr[wb_addr_width-1];
    assign lane      = dir_t'(wb_adr[addr_width +: 4]);
    assign host_cell = wb_adr[addr_width-1:0];
    assign reg_off   = int'(wb_adr[wb_addr_width-2:0]);

    always_comb
    begin
        case (reg_off)
            reg_step_target: reg_rdata = step_target;
            reg_step_count:  reg_rdata = step_count;
            reg_status:      reg_rdata = {15'd0, busy};
            default:         reg_rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wb_ack      <= 1'b0;
            rd_pend     <= 1'b0;
            step_target <= 16'd0;
        end
        else
        begin
            wb_ack  <= 1'b0;
            rd_pend <= 1'b0;
            if (rd_pend)
            begin
                wb_ack <= 1'b1;
            end
            else if (req && (!lat_sel || wb_we))
            begin
                wb_ack <= 1'b1;    // Lattice is read only
                if (!lat_sel && wb_we && reg_off == reg_step_target)
                    step_target <= wb_dat_w;
            end
            else if (req && host_grant)
            begin
                rd_pend <= 1'b1;    // Address cycle
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_pend)
            wb_dat_r <= (lane < num_dir) ? rd_data[lane] : '0;
        else if (req && !lat_sel)
            wb_dat_r <= reg_rdata;
    end

    a_ack_pulse : assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* design/stream_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_unit (
    input  wire                                          clk,
    input  wire lbm_pkg::sweep_phase_t                   phase,
    input  wire lbm_pkg::cell_addr_t                     index,
    input  wire lbm_pkg::cell_addr_t                     col,
    input  wire                                          page,
    input  wire                                          wait_done,
    input  wire [lbm_pkg::lat_depth-1:0]                 barriers,
    input  wire lbm_pkg::dist_vec_t                      init_dist,
    input  wire lbm_pkg::dist_vec_t                      rd_data,
    input  wire                                          host_grant,
    input  wire lbm_pkg::cell_addr_t                     host_cell,
    output lbm_pkg::cell_addr_t [lbm_pkg::num_dir-1:0]   mem_addr,
    output logic [lbm_pkg::num_dir-1:0]                  mem_page,
    output logic [lbm_pkg::num_dir-1:0]                  mem_we,
    output lbm_pkg::dist_vec_t                           mem_wdata,
    output logic                                         init_both
);
    import lbm_pkg::*;

    int tgt [num_dir];    // Neighbour cell per direction

    always_comb
    begin
        for (int d = 0; d < num_dir; d++)
            tgt[d] = int'(index) + dir_dy[d] * lat_width + dir_dx[d];
    end

    //////////////////////////////////////////////////////////////////////
    // Memory access per phase
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        init_both = 1'b0;
        mem_page  = {num_dir{page}};    // Reads come from the current page
        mem_we    = '0;
        mem_wdata = '0;
        for (int d = 0; d < num_dir; d++)
            mem_addr[d] = index;

        case (phase)
            phase_init:
            begin
                init_both = 1'b1;
                mem_we    = '1;
                for (int d = 0; d < num_dir; d++)
                    mem_wdata[d] = barriers[index] ? dist_t'(0) : init_dist[d];
            end

            phase_idle:
            begin
                if (host_grant)
                begin
                    for (int d = 0; d < num_dir; d++)
                        mem_addr[d] = host_cell;
                end
            end

            phase_stream_wait:
            begin
                if (wait_done)
                begin
                    mem_page  = {num_dir{~page}};
                    mem_we    = '1;
                    mem_wdata = rd_data;
                    for (int d = 0; d < num_dir; d++)
                        mem_addr[d] = cell_addr_t'(tgt[d]);
                end
            end

            phase_zero:
            begin
                if (barriers[index])
                begin
                    mem_page = {num_dir{~page}};    // Write data stays zero
                    mem_we   = '1;
                end
            end

            default: ;    // Stream read at index
        endcase
    end

    // A pushed value lands inside the grid and never wraps a row
    for (genvar d = 0; d < num_dir; d++)
    begin : g_chk
        a_stream_target : assert property (@(posedge clk)
            (phase == phase_stream_wait && mem_we[d]) |->
                (tgt[d] >= 0 && tgt[d] < lat_depth &&
                 int'(col) + dir_dx[d] >= 0 && int'(col) + dir_dx[d] < lat_width));
    end

endmodule

`default_nettype wire

/* design/sweep_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sweep_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [lbm_pkg::lat_depth-1:0] barriers,
    input  wire [15:0]                   step_target,
    output lbm_pkg::sweep_phase_t        phase,
    output lbm_pkg::cell_addr_t          index,
    output lbm_pkg::cell_addr_t          col,
    output logic                         page,
    output logic                         wait_done,
    output logic                         busy,
    output logic [15:0]                  step_count,
    output logic                         host_grant
);
    import lbm_pkg::*;

    logic [1:0] wait_cnt;
    logic       step_pending;
    logic       last_cell;
    logic       last_interior;
    logic       row_end;          // Last interior column

    assign step_pending  = step_count < step_target;
    assign last_cell     = index == cell_addr_t'(lat_depth - 1);
    assign last_interior = index == cell_addr_t'(lat_depth - lat_width - 2);
    assign row_end       = col == cell_addr_t'(lat_width - 2);
    assign wait_done     = (phase == phase_stream_wait) && (wait_cnt == 2'd0);

    // Host may only touch memory when no step is running or due
    assign host_grant = (phase == phase_idle) && !step_pending;
    assign busy       = !host_grant;

    //////////////////////////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            phase      <= phase_init;
            index      <= '0;
            col        <= '0;
            wait_cnt   <= 2'd0;
            step_count <= 16'd0;
            page       <= 1'b0;
        end
        else
        begin
            case (phase)
                phase_init, phase_zero:
                begin
                    // Full sweeps visit every cell in order
                    if (last_cell)
                    begin
                        phase <= phase_idle;
                        index <= '0;
                        col   <= '0;
                        if (phase == phase_zero)
                        begin
                            page       <= ~page;    // Next page becomes current
                            step_count <= step_count + 16'd1;
                        end
                    end
                    else
                    begin
                        index <= index + cell_addr_t'(1);
                        col   <= (col == cell_addr_t'(lat_width - 1)) ? '0 : col + cell_addr_t'(1);
                    end
                end

                phase_idle:
                begin
                    if (step_pending)
                    begin
                        phase <= phase_stream;
                        index <= cell_addr_t'(lat_width + 1);
                        col   <= cell_addr_t'(1);
                    end
                end

                phase_stream, phase_stream_wait:
                begin
                    if (phase == phase_stream && !barriers[index])
                    begin
                        phase    <= phase_stream_wait;    // Read issued this cycle
                        wait_cnt <= 2'(ram_read_wait);
                    end
                    else if (wait_cnt != 2'd0)
                    begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                    else if (last_interior)
                    begin
                        phase <= phase_zero;
                        index <= '0;
                        col   <= '0;
                    end
                    else
                    begin
                        // Skip the two edge columns at a row end
                        phase <= phase_stream;
                        index <= index + (row_end ? cell_addr_t'(3) : cell_addr_t'(1));
                        col   <= row_end ? cell_addr_t'(1) : col + cell_addr_t'(1);
                    end
                end

                default: phase <= phase_idle;
            endcase
        end
    end

    // Streaming stays on interior cells and col follows the index
    a_interior : assert property (@(posedge clk) disable iff (!rst)
        (phase inside {phase_stream, phase_stream_wait}) |->
            (int'(index) >= lat_width && int'(index) < lat_depth - lat_width &&
             int'(index) % lat_width == int'(col) &&
             col != '0 && int'(col) != lat_width - 1));

    a_page_swap : assert property (@(posedge clk) disable iff (!rst)
        (page != $past(page)) |-> ($past(phase) == phase_zero && phase == phase_idle));

endmodule

`default_nettype wire

/* design/lattice_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module lattice_mem (
    input  wire                                              clk,
    input  wire lbm_pkg::cell_addr_t [lbm_pkg::num_dir-1:0]  mem_addr,
    input  wire [lbm_pkg::num_dir-1:0]                       mem_page,
    input  wire [lbm_pkg::num_dir-1:0]                       mem_we,
    input  wire lbm_pkg::dist_vec_t                          mem_wdata,
    input  wire                                              init_both,
    output wire lbm_pkg::dist_vec_t                          rd_data
);
    import lbm_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // One single-port store per direction, split into two pages
    //////////////////////////////////////////////////////////////////////

    for (genvar d = 0; d < num_dir; d++)
    begin : g_dir
        dist_t mem [2][lat_depth];    // [page][cell]
        dist_t rd_q;

        always_ff @(posedge clk)
        begin
            if (mem_we[d])
            begin
                if (init_both)
                begin
                    // Lattice setup fills both pages at once
                    mem[0][mem_addr[d]] <= mem_wdata[d];
                    mem[1][mem_addr[d]] <= mem_wdata[d];
                end
                else
                begin
                    mem[mem_page[d]][mem_addr[d]] <= mem_wdata[d];
                end
            end
            rd_q <= mem[mem_page[d]][mem_addr[d]];    // Old data on a same-cell write
        end

        assign rd_data[d] = rd_q;
    end

endmodule

`default_nettype wire

/* design/lbm_pkg.sv */
`default_nettype none

package lbm_pkg;

    // Lattice geometry
    localparam int lat_width  = 8;
    localparam int lat_height = 8;
    localparam int lat_depth  = lat_width * lat_height;
    localparam int addr_width = 6;
    localparam int data_width = 16;
    localparam int num_dir    = 9;

    localparam int ram_read_wait = 1;    // Idle cycles before read data is valid

    typedef logic [addr_width-1:0] cell_addr_t;
    typedef logic signed [data_width-1:0] dist_t;
    typedef dist_t [num_dir-1:0] dist_vec_t;

    typedef enum logic [3:0] {
        d_0,
        d_n,
        d_ne,
        d_e,
        d_se,
        d_s,
        d_sw,
        d_w,
        d_nw
    } dir_t;

    // Neighbour step per direction, north is one row up
    localparam int dir_dx [num_dir] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int dir_dy [num_dir] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    typedef enum logic [2:0] {
        phase_init,
        phase_idle,
        phase_stream,
        phase_stream_wait,
        phase_zero
    } sweep_phase_t;

    // Host map, top address bit selects the lattice
    localparam int wb_addr_width   = 11;
    localparam int reg_step_target = 0;
    localparam int reg_step_count  = 1;
    localparam int reg_status      = 2;

endpackage

`default_nettype wire
